// File: wiscSystem.f
rtl/wiscPkg.sv
rtl/memPortIf.sv
rtl/memArbiter.sv
rtl/unifiedMem.sv
rtl/fetchStage.sv
rtl/decodeStage.sv
rtl/executeStage.sv
rtl/memoryStage.sv
rtl/proc.sv
rtl/wiscSystem.sv
verification/memArbiter_props.sv
verification/wiscSystem_tb.sv

// File: Makefile
TOOL     := verilator
FLAGS    := --binary --timing --assert -j 0
TOP      := wiscSystem_tb
FILELIST := wiscSystem.f
LOG      := sim.log

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "^\*\*\* PASSED \*\*\*$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: verification/wiscSystem_tb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// programs sit in words 0..11, operands in 12 and 13, result in 14
// r0 is never written by a program, so it works as a zero base
// err is sticky, so the illegal-opcode row must stay last
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module wiscSystem_tb;
	import wiscPkg::*;

	localparam int PROG_WORDS = 12;
	localparam int GRANT_LIMIT = 8;
	localparam int HALT_LIMIT = 300;
	localparam logic [7:0] ADDR_A = 8'd12;
	localparam logic [7:0] ADDR_B = 8'd13;
	localparam logic [7:0] ADDR_RES = 8'd14;
	localparam logic [15:0] SENTINEL = 16'hDEAD;
	localparam logic [15:0] MARKER = 16'h0007;

	typedef enum logic [2:0] {KIND_ALU, KIND_ADDI, KIND_BEQZ, KIND_HOSTRD, KIND_ILLEGAL} kindT;

	typedef struct packed {
		kindT        kind;
		opcodeT      op;
		logic [15:0] a;
		logic [15:0] b;
		logic [15:0] expected;
		logic        expErr;
	} testRowT;

	logic        clk;
	logic        arstN;
	logic        run;
	logic        hostReq;
	logic        hostWe;
	logic [7:0]  hostAddr;
	logic [15:0] hostWdata;
	logic        hostGrant;
	logic [15:0] hostRdata;
	logic        halted;
	logic        err;

	testRowT     rows [$];
	logic [15:0] progWords [PROG_WORDS];
	logic [15:0] lfsrState;
	bit          testOk;
	int          passCount;
	int          failCount;

	wiscSystem DUT (
		.clk, .arstN, .run, .hostReq, .hostWe, .hostAddr, .hostWdata,
		.hostGrant, .hostRdata, .halted, .err
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// Galois form, taps for x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsrNext(input logic [15:0] s);
		return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
	endfunction

	task automatic randBits(input int n, output logic [15:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsrState = lfsrNext(lfsrState);
			v = {v[14:0], lfsrState[0]};
		end
	endtask

	function automatic logic [15:0] sext5(input logic [4:0] v);
		return {{11{v[4]}}, v};
	endfunction

	function automatic logic [15:0] rType(input opcodeT op, input logic [2:0] rd,
		input logic [2:0] rs, input logic [2:0] rt);
		return {op, rd, rs, rt, 2'b00};
	endfunction

	function automatic logic [15:0] iType(input opcodeT op, input logic [2:0] rd,
		input logic [2:0] rs, input logic [4:0] imm);
		return {op, rd, rs, imm};
	endfunction

	// result word each program should leave behind
	function automatic logic [15:0] expectFor(input kindT kind, input opcodeT op,
		input logic [15:0] a, input logic [15:0] b);
		case (kind)
			KIND_ALU, KIND_HOSTRD: begin
				case (op)
					OP_ADD: return a + b;
					OP_SUB: return a - b;
					OP_AND: return a & b;
					default: return a ^ b;
				endcase
			end
			KIND_ADDI: return sext5(a[4:0]) + sext5(b[4:0]) + sext5(a[4:0]);
			KIND_BEQZ: return (a == 16'd0) ? SENTINEL : MARKER;
			default: return SENTINEL;
		endcase
	endfunction

	function automatic string kindName(input kindT kind);
		case (kind)
			KIND_ALU: return "alu";
			KIND_ADDI: return "addi chain";
			KIND_BEQZ: return "beqz";
			KIND_HOSTRD: return "host reads";
			default: return "illegal opcode";
		endcase
	endfunction

	task automatic addRow(input kindT kind, input opcodeT op, input logic [15:0] a,
		input logic [15:0] b);
		testRowT row;
		row.kind = kind;
		row.op = op;
		row.a = a;
		row.b = b;
		row.expected = expectFor(kind, op, a, b);
		row.expErr = (kind == KIND_ILLEGAL);
		rows.push_back(row);
	endtask

	task automatic buildTable();
		opcodeT      aluOps [4] = '{OP_ADD, OP_SUB, OP_AND, OP_XOR};
		logic [15:0] a;
		logic [15:0] b;
		foreach (aluOps[i]) begin
			randBits(16, a);
			randBits(16, b);
			addRow(KIND_ALU, aluOps[i], a, b);
		end
		// carry and borrow out of bit 15
		addRow(KIND_ALU, OP_ADD, 16'hFFFF, 16'h0002);
		addRow(KIND_ALU, OP_SUB, 16'h0000, 16'h0001);
		// -1 and -16 as immediates
		addRow(KIND_ADDI, OP_ADDI, 16'h001F, 16'h0010);
		addRow(KIND_ADDI, OP_ADDI, 16'h0007, 16'h0003);
		randBits(5, a);
		randBits(5, b);
		addRow(KIND_ADDI, OP_ADDI, a, b);
		addRow(KIND_BEQZ, OP_BEQZ, 16'h0000, 16'h0000);
		addRow(KIND_BEQZ, OP_BEQZ, 16'h8000, 16'h0000);
		randBits(16, a);
		addRow(KIND_BEQZ, OP_BEQZ, a | 16'h0001, 16'h0000);
		randBits(16, a);
		randBits(16, b);
		addRow(KIND_HOSTRD, OP_ADD, a, b);
		randBits(16, a);
		randBits(16, b);
		addRow(KIND_HOSTRD, OP_XOR, a, b);
		addRow(KIND_ILLEGAL, OP_HALT, 16'h0000, 16'h0000);
	endtask

	task automatic buildProgram(input testRowT row);
		for (int w = 0; w < PROG_WORDS; w++) begin
			progWords[w] = iType(OP_HALT, 3'd0, 3'd0, 5'd0);
		end
		case (row.kind)
			KIND_ALU, KIND_HOSTRD: begin
				progWords[0] = iType(OP_LD, 3'd1, 3'd0, ADDR_A[4:0]);
				progWords[1] = iType(OP_LD, 3'd2, 3'd0, ADDR_B[4:0]);
				progWords[2] = rType(row.op, 3'd3, 3'd1, 3'd2);
				progWords[3] = iType(OP_ST, 3'd3, 3'd0, ADDR_RES[4:0]);
			end
			KIND_ADDI: begin
				progWords[0] = iType(OP_ADDI, 3'd1, 3'd0, row.a[4:0]);
				progWords[1] = iType(OP_ADDI, 3'd2, 3'd1, row.b[4:0]);
				progWords[2] = iType(OP_ADDI, 3'd3, 3'd2, row.a[4:0]);
				progWords[3] = iType(OP_ST, 3'd3, 3'd0, ADDR_RES[4:0]);
			end
			KIND_BEQZ: begin
				progWords[0] = iType(OP_LD, 3'd1, 3'd0, ADDR_A[4:0]);
				progWords[1] = iType(OP_ADDI, 3'd2, 3'd0, MARKER[4:0]);
				// offset 1 from the next word skips the marker store
				progWords[2] = {OP_BEQZ, 3'd1, 8'd1};
				progWords[3] = iType(OP_ST, 3'd2, 3'd0, ADDR_RES[4:0]);
			end
			default: begin
				progWords[0] = iType(OP_ADDI, 3'd2, 3'd0, MARKER[4:0]);
				progWords[1] = {5'b11111, 11'd0};
				progWords[2] = iType(OP_ST, 3'd2, 3'd0, ADDR_RES[4:0]);
			end
		endcase
	endtask

	task automatic checkEqual(input string name, input logic [15:0] got,
		input logic [15:0] exp);
		assert (got === exp) else begin
			$display("** Error: %s = 0x%h, expected 0x%h", name, got, exp);
			testOk = 1'b0;
		end
	endtask

	// grant is combinational from hostReq, so it is stable at the edge
	task automatic awaitHostGrant(output bit granted);
		int cycles;
		granted = 1'b0;
		cycles = 0;
		while (!granted && cycles < GRANT_LIMIT) begin
			@(posedge clk);
			granted = hostGrant;
			@(negedge clk);
			cycles++;
		end
	endtask

	task automatic hostWrite(input logic [7:0] addr, input logic [15:0] data);
		bit granted;
		hostReq = 1'b1;
		hostWe = 1'b1;
		hostAddr = addr;
		hostWdata = data;
		awaitHostGrant(granted);
		hostReq = 1'b0;
		hostWe = 1'b0;
		assert (granted) else begin
			$display("host write to word 0x%h was never granted", addr);
			testOk = 1'b0;
		end
	endtask

	task automatic hostRead(input logic [7:0] addr, output logic [15:0] data);
		bit granted;
		data = '0;
		hostReq = 1'b1;
		hostWe = 1'b0;
		hostAddr = addr;
		awaitHostGrant(granted);
		// read data is valid one cycle after the grant
		if (granted) begin
			data = hostRdata;
		end
		hostReq = 1'b0;
		assert (granted) else begin
			$display("host read of word 0x%h was never granted", addr);
			testOk = 1'b0;
		end
	endtask

	task automatic pulseRun();
		run = 1'b1;
		@(negedge clk);
		run = 1'b0;
	endtask

	task automatic waitHalted();
		int cycles;
		cycles = 0;
		while (!halted && cycles < HALT_LIMIT) begin
			@(negedge clk);
			cycles++;
		end
		assert (halted) else begin
			$display("core did not halt within %0d cycles", HALT_LIMIT);
			testOk = 1'b0;
		end
	endtask

	task automatic finishTest(input string label);
		$display("%-24s %s", label, testOk ? "pass" : "fail");
		if (testOk) begin
			passCount++;
		end else begin
			failCount++;
		end
	endtask

	task automatic checkReset();
		testOk = 1'b1;
		checkEqual("halted", 16'(halted), 16'd0);
		checkEqual("err", 16'(err), 16'd0);
		checkEqual("hostGrant", 16'(hostGrant), 16'd0);
		finishTest("reset state");
	endtask

	task automatic runRow(input int idx);
		testRowT     row;
		logic [15:0] rdVal;
		int          reads;
		int          cycles;
		row = rows[idx];
		testOk = 1'b1;
		buildProgram(row);
		for (int w = 0; w < PROG_WORDS; w++) begin
			hostWrite(8'(w), progWords[w]);
		end
		hostWrite(ADDR_A, row.a);
		hostWrite(ADDR_B, row.b);
		hostWrite(ADDR_RES, SENTINEL);
		pulseRun();
		if (row.kind == KIND_HOSTRD) begin
			reads = 0;
			cycles = 0;
			// one idle cycle between reads lets the core progress
			while (!halted && cycles < HALT_LIMIT) begin
				hostRead(ADDR_A, rdVal);
				checkEqual("hostRdata", rdVal, row.a);
				reads++;
				@(negedge clk);
				cycles += 2;
			end
			assert (reads > 1) else begin
				$display("host read only %0d times while the core ran", reads);
				testOk = 1'b0;
			end
		end
		waitHalted();
		checkEqual("halted", 16'(halted), 16'd1);
		checkEqual("err", 16'(err), 16'(row.expErr));
		hostRead(ADDR_RES, rdVal);
		checkEqual("hostRdata", rdVal, row.expected);
		finishTest($sformatf("row %0d %s", idx, kindName(row.kind)));
	endtask

	initial begin
		lfsrState = 16'd81;
		passCount = 0;
		failCount = 0;
		arstN = 1'b0;
		run = 1'b0;
		hostReq = 1'b0;
		hostWe = 1'b0;
		hostAddr = '0;
		hostWdata = '0;
		repeat (10) @(negedge clk);
		arstN = 1'b1;
		@(negedge clk);
		checkReset();
		buildTable();
		foreach (rows[i]) begin
			runRow(i);
		end
		$display("tests %0d, passed %0d, failed %0d", passCount + failCount, passCount,
			failCount);
		if (failCount == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: verification/memArbiter_props.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// sampled on the rising edge, idle while reset is asserted
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module memArbiterProps (
	input logic                       clk,
	input logic                       arstN,
	input logic                       hostReq,
	input logic                       dataReq,
	input logic                       fetchReq,
	input logic                       hostGnt,
	input logic                       dataGnt,
	input logic                       fetchGnt,
	input logic                       hostWe,
	input logic [wiscPkg::ADDR_W-1:0] hostAddr,
	input logic [wiscPkg::DATA_W-1:0] hostWdata,
	input logic [wiscPkg::ADDR_W-1:0] dataAddr,
	input logic [wiscPkg::ADDR_W-1:0] fetchAddr,
	input logic                       memWe,
	input logic [wiscPkg::ADDR_W-1:0] memAddr,
	input logic [wiscPkg::DATA_W-1:0] memWdata
);

	// single memory port, so one owner per cycle
	oneGrant: assert property (@(posedge clk) disable iff (!arstN)
		$onehot0({hostGnt, dataGnt, fetchGnt}))
		else $error("arbiter issued more than one grant in a cycle");

	// the granted port's address is the one that reaches memory
	grantNeedsReq: assert property (@(posedge clk) disable iff (!arstN)
		(!hostGnt || hostReq) && (!dataGnt || (dataReq && memAddr == dataAddr))
		&& (!fetchGnt || (fetchReq && memAddr == fetchAddr && !memWe)))
		else $error("arbiter granted an idle port or sent the wrong address");

	// host sits at the top of the priority order
	hostAlwaysWins: assert property (@(posedge clk) disable iff (!arstN)
		hostReq |-> hostGnt && memAddr == hostAddr && memWe == hostWe
			&& (!hostWe || memWdata == hostWdata))
		else $error("host request did not reach memory in its cycle");

endmodule

bind memArbiter memArbiterProps uArbiterProps (
	.clk, .arstN, .hostGnt, .dataGnt, .fetchGnt, .memWe, .memAddr, .memWdata,
	.hostReq(hostPort.req),
	.dataReq(dataPort.req),
	.fetchReq(fetchPort.req),
	.hostWe(hostPort.we),
	.hostAddr(hostPort.addr),
	.hostWdata(hostPort.wdata),
	.dataAddr(dataPort.addr),
	.fetchAddr(fetchPort.addr)
);

`default_nettype wire

// File: rtl/wiscSystem.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// host port always wins arbitration, read data one cycle later
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module wiscSystem (
	input  logic                       clk,
	input  logic                       arstN,
	input  logic                       run,
	input  logic                       hostReq,
	input  logic                       hostWe,
	input  logic [wiscPkg::ADDR_W-1:0] hostAddr,
	input  logic [wiscPkg::DATA_W-1:0] hostWdata,
	output logic                       hostGrant,
	output logic [wiscPkg::DATA_W-1:0] hostRdata,
	output logic                       halted,
	output logic                       err
);
	import wiscPkg::*;

	memPortIf hostIf ();
	memPortIf dataIf ();
	memPortIf fetchIf ();

	logic              memReq, memWe;
	logic [ADDR_W-1:0] memAddr;
	logic [DATA_W-1:0] memWdata, memRdata;

	assign hostIf.req = hostReq;
	assign hostIf.we = hostWe;
	assign hostIf.addr = hostAddr;
	assign hostIf.wdata = hostWdata;
	assign hostGrant = hostIf.grant;
	assign hostRdata = hostIf.rdata;

	proc uProc (
		.clk, .arstN, .run, .halted, .err,
		.fetchPort(fetchIf.requester),
		.dataPort(dataIf.requester)
	);

	memArbiter uArbiter (
		.clk, .arstN, .memReq, .memWe, .memAddr, .memWdata, .memRdata,
		.hostPort(hostIf.arbiter),
		.dataPort(dataIf.arbiter),
		.fetchPort(fetchIf.arbiter)
	);

	unifiedMem uMem (
		.clk, .memReq, .memWe, .memAddr, .memWdata, .memRdata
	);

endmodule

`default_nettype wire

// File: rtl/proc.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// a rising run restarts at PC 0, halted clears on a falling run
// err stays set until reset
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module proc (
	input  logic        clk,
	input  logic        arstN,
	input  logic        run,
	memPortIf.requester fetchPort,
	memPortIf.requester dataPort,
	output logic        halted,
	output logic        err
);
	import wiscPkg::*;

	procStateT state;
	logic      runQ, start, freeze, redirect, exIllegal, kill;

	logic [DATA_W-1:0] instr;
	logic              instrValid, interlock;
	logic [ADDR_W-1:0] instrPc;

	opcodeT            idOp, exOp, memOp;
	logic [REG_W-1:0]  idDest, exDest, memDest, wbDest;
	logic [DATA_W-1:0] idA, idB, idImm, exA, exB, exImm;
	logic [ADDR_W-1:0] idPcNext, exPcNext, branchTarget;
	logic              exValid, memValid, branchTaken, illegal;
	logic [DATA_W-1:0] exResult, memResult, memStore, wbData;
	logic              dataStall, wbWrite, haltSeen;

	assign start = (state == RUN);
	assign halted = (state == HALTED);
	// only a data port blocked by the host freezes everything
	assign freeze = dataStall;
	assign redirect = start && exValid && branchTaken && !freeze;
	// ops behind a HALT in memory never count
	assign exIllegal = exValid && illegal && !freeze && !haltSeen;
	assign kill = !start || haltSeen || exIllegal;

	fetchStage uFetch (
		.clk, .arstN, .start, .redirect, .fetchPort, .instr, .instrValid, .instrPc,
		.hold(freeze || interlock),
		.redirectPc(branchTarget)
	);

	decodeStage uDecode (
		.clk, .arstN, .instr, .instrValid, .instrPc, .exDest, .memDest,
		.wbWrite, .wbDest, .wbData, .interlock,
		.exWrites(exValid && writesRd(exOp)),
		.memWrites(memValid && writesRd(memOp)),
		.opcode(idOp), .dest(idDest), .srcA(idA), .srcB(idB), .imm(idImm), .pcNext(idPcNext)
	);

	executeStage uExecute (
		.opcode(exOp), .srcA(exA), .srcB(exB), .imm(exImm), .pcNext(exPcNext),
		.result(exResult), .branchTaken, .branchTarget, .illegal
	);

	memoryStage uMemory (
		.clk, .arstN, .dataPort, .dataStall, .wbWrite, .wbDest, .wbData, .haltSeen,
		.opcode(memOp), .addr(memResult), .storeData(memStore), .dest(memDest),
		.valid(memValid)
	);

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			state <= IDLE;
			runQ <= 1'b0;
			err <= 1'b0;
		end else begin
			runQ <= run;
			if (exIllegal) begin
				err <= 1'b1;
			end
			case (state)
				IDLE: if (run && !runQ) state <= RUN;
				RUN: if (haltSeen || exIllegal) state <= HALTED;
				HALTED: begin
					if (run && !runQ) begin
						state <= RUN;
					end else if (!run && runQ) begin
						state <= IDLE;
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

	// interlock and squashed slots enter execute as bubbles
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			exValid <= 1'b0;
			memValid <= 1'b0;
		end else if (!freeze) begin
			exValid <= !kill && !redirect && instrValid && !interlock;
			memValid <= !kill && exValid;
		end
	end

	always_ff @(posedge clk) begin
		if (!freeze) begin
			exOp <= idOp;
			exDest <= idDest;
			exA <= idA;
			exB <= idB;
			exImm <= idImm;
			exPcNext <= idPcNext;
			memOp <= exOp;
			memDest <= exDest;
			memResult <= exResult;
			memStore <= exB;
		end
	end

endmodule

`default_nettype wire

// File: rtl/memoryStage.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// addr carries the ALU result for non-memory ops
// writeback happens one cycle after the op leaves this stage
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module memoryStage (
	input  logic                       clk,
	input  logic                       arstN,
	input  wiscPkg::opcodeT            opcode,
	input  logic [wiscPkg::DATA_W-1:0] addr,
	input  logic [wiscPkg::DATA_W-1:0] storeData,
	input  logic [wiscPkg::REG_W-1:0]  dest,
	input  logic                       valid,
	memPortIf.requester                dataPort,
	output logic                       dataStall,
	output logic                       wbWrite,
	output logic [wiscPkg::REG_W-1:0]  wbDest,
	output logic [wiscPkg::DATA_W-1:0] wbData,
	output logic                       haltSeen
);
	import wiscPkg::*;

	logic              isLoad, isStore, wbLoad;
	logic [DATA_W-1:0] wbAlu;

	assign isLoad = valid && (opcode == OP_LD);
	assign isStore = valid && (opcode == OP_ST);
	assign haltSeen = valid && (opcode == OP_HALT);

	assign dataPort.req = isLoad || isStore;
	assign dataPort.we = isStore;
	assign dataPort.addr = addr[ADDR_W-1:0];
	assign dataPort.wdata = storeData;
	// request stays up until granted
	assign dataStall = dataPort.req && !dataPort.grant;

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			wbWrite <= 1'b0;
			wbLoad <= 1'b0;
		end else begin
			wbWrite <= valid && writesRd(opcode) && !dataStall;
			wbLoad <= isLoad;
		end
	end

	always_ff @(posedge clk) begin
		wbDest <= dest;
		wbAlu <= addr;
	end

	// load data arrives the cycle after grant
	assign wbData = wbLoad ? dataPort.rdata : wbAlu;

endmodule

`default_nettype wire

// File: rtl/executeStage.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// branch target wraps within the word address space
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module executeStage (
	input  wiscPkg::opcodeT            opcode,
	input  logic [wiscPkg::DATA_W-1:0] srcA,
	input  logic [wiscPkg::DATA_W-1:0] srcB,
	input  logic [wiscPkg::DATA_W-1:0] imm,
	input  logic [wiscPkg::ADDR_W-1:0] pcNext,
	output logic [wiscPkg::DATA_W-1:0] result,
	output logic                       branchTaken,
	output logic [wiscPkg::ADDR_W-1:0] branchTarget,
	output logic                       illegal
);
	import wiscPkg::*;

	// offset is relative to the word after the branch
	assign branchTarget = pcNext + imm[ADDR_W-1:0];

	always_comb begin
		result = '0;
		branchTaken = 1'b0;
		illegal = 1'b0;
		case (opcode)
			OP_ADD: result = srcA + srcB;
			OP_SUB: result = srcA - srcB;
			OP_AND: result = srcA & srcB;
			OP_XOR: result = srcA ^ srcB;
			// address generation shares the adder
			OP_ADDI, OP_LD, OP_ST: result = srcA + imm;
			OP_BEQZ: branchTaken = (srcA == '0);
			OP_HALT: result = '0;
			default: illegal = 1'b1;
		endcase
	end

endmodule

`default_nettype wire

// File: rtl/decodeStage.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// no forwarding, so any pending write to a source holds decode
// registers clear to zero on reset
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module decodeStage (
	input  logic                       clk,
	input  logic                       arstN,
	input  logic [wiscPkg::DATA_W-1:0] instr,
	input  logic                       instrValid,
	input  logic [wiscPkg::ADDR_W-1:0] instrPc,
	input  logic [wiscPkg::REG_W-1:0]  exDest,
	input  logic                       exWrites,
	input  logic [wiscPkg::REG_W-1:0]  memDest,
	input  logic                       memWrites,
	input  logic                       wbWrite,
	input  logic [wiscPkg::REG_W-1:0]  wbDest,
	input  logic [wiscPkg::DATA_W-1:0] wbData,
	output wiscPkg::opcodeT            opcode,
	output logic [wiscPkg::REG_W-1:0]  dest,
	output logic [wiscPkg::DATA_W-1:0] srcA,
	output logic [wiscPkg::DATA_W-1:0] srcB,
	output logic [wiscPkg::DATA_W-1:0] imm,
	output logic [wiscPkg::ADDR_W-1:0] pcNext,
	output logic                       interlock
);
	import wiscPkg::*;

	logic [DATA_W-1:0] regs [REG_CNT];
	logic [REG_W-1:0]  rd, rs, rt, idxA, idxB;
	logic              isAlu, useA, useB, hazA, hazB;

	assign opcode = opcodeT'(instr[15:11]);
	assign rd = instr[10:8];
	assign rs = instr[7:5];
	assign rt = instr[4:2];
	assign dest = rd;
	assign pcNext = instrPc + ADDR_W'(1);

	// BEQZ tests Rd, ST stores Rd
	assign isAlu = opcode inside {OP_ADD, OP_SUB, OP_AND, OP_XOR};
	assign useA = isAlu || (opcode inside {OP_ADDI, OP_LD, OP_ST, OP_BEQZ});
	assign useB = isAlu || (opcode == OP_ST);
	assign idxA = (opcode == OP_BEQZ) ? rd : rs;
	assign idxB = (opcode == OP_ST) ? rd : rt;

	// 8-bit branch offset, 5-bit immediate otherwise
	assign imm = (opcode == OP_BEQZ) ? {{(DATA_W-8){instr[7]}}, instr[7:0]}
		: {{(DATA_W-5){instr[4]}}, instr[4:0]};

	// write-through read
	assign srcA = (wbWrite && wbDest == idxA) ? wbData : regs[idxA];
	assign srcB = (wbWrite && wbDest == idxB) ? wbData : regs[idxB];

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			for (int i = 0; i < REG_CNT; i++) begin
				regs[i] <= '0;
			end
		end else if (wbWrite) begin
			regs[wbDest] <= wbData;
		end
	end

	// writeback needs no check, it is covered by write-through
	assign hazA = useA && ((exWrites && exDest == idxA) || (memWrites && memDest == idxA));
	assign hazB = useB && ((exWrites && exDest == idxB) || (memWrites && memDest == idxB));
	assign interlock = instrValid && (hazA || hazB);

endmodule

`default_nettype wire

// File: rtl/fetchStage.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// PC steps by one word and restarts at 0 whenever start is low
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module fetchStage (
	input  logic                       clk,
	input  logic                       arstN,
	input  logic                       start,
	input  logic                       hold,
	input  logic                       redirect,
	input  logic [wiscPkg::ADDR_W-1:0] redirectPc,
	memPortIf.requester                fetchPort,
	output logic [wiscPkg::DATA_W-1:0] instr,
	output logic                       instrValid,
	output logic [wiscPkg::ADDR_W-1:0] instrPc
);
	import wiscPkg::*;

	logic [ADDR_W-1:0] pc, pendPc, holdPc;
	logic [DATA_W-1:0] holdInstr;
	logic              pendValid, holdValid;

	// no new fetch while decode is held
	assign fetchPort.req = start && !hold;
	assign fetchPort.we = 1'b0;
	assign fetchPort.addr = pc;
	assign fetchPort.wdata = '0;

	// held word wins over the read returning now
	assign instrValid = holdValid || pendValid;
	assign instr = holdValid ? holdInstr : fetchPort.rdata;
	assign instrPc = holdValid ? holdPc : pendPc;

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			pc <= '0;
			pendValid <= 1'b0;
			holdValid <= 1'b0;
		end else if (!start) begin
			pc <= '0;
			pendValid <= 1'b0;
			holdValid <= 1'b0;
		end else if (redirect) begin
			// read in flight belongs to the wrong path
			pc <= redirectPc;
			pendValid <= 1'b0;
			holdValid <= 1'b0;
		end else begin
			if (fetchPort.grant) begin
				pc <= pc + ADDR_W'(1);
			end
			pendValid <= fetchPort.grant;
			holdValid <= hold && instrValid;
		end
	end

	always_ff @(posedge clk) begin
		if (fetchPort.grant) begin
			pendPc <= pc;
		end
		if (hold && !holdValid) begin
			holdInstr <= fetchPort.rdata;
			holdPc <= pendPc;
		end
	end

endmodule

`default_nettype wire

// File: rtl/unifiedMem.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// contents are undefined until written through a port
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module unifiedMem (
	input  logic                       clk,
	input  logic                       memReq,
	input  logic                       memWe,
	input  logic [wiscPkg::ADDR_W-1:0] memAddr,
	input  logic [wiscPkg::DATA_W-1:0] memWdata,
	output logic [wiscPkg::DATA_W-1:0] memRdata
);
	import wiscPkg::*;

	logic [DATA_W-1:0] words [MEM_DEPTH];

	// rdata holds its last value when no read is issued
	always_ff @(posedge clk) begin
		if (memReq && memWe) begin
			words[memAddr] <= memWdata;
		end else if (memReq) begin
			memRdata <= words[memAddr];
		end
	end

endmodule

`default_nettype wire

// File: rtl/memArbiter.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// fixed priority host > data > fetch with no fairness
// a port that loses must keep its request up
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module memArbiter (
	input  logic                       clk,
	input  logic                       arstN,
	memPortIf.arbiter                  hostPort,
	memPortIf.arbiter                  dataPort,
	memPortIf.arbiter                  fetchPort,
	output logic                       memReq,
	output logic                       memWe,
	output logic [wiscPkg::ADDR_W-1:0] memAddr,
	output logic [wiscPkg::DATA_W-1:0] memWdata,
	input  logic [wiscPkg::DATA_W-1:0] memRdata
);

	logic hostGnt, dataGnt, fetchGnt;
	// owner of the read returning this cycle
	logic hostRd, dataRd, fetchRd;

	assign hostGnt = hostPort.req;
	assign dataGnt = dataPort.req && !hostPort.req;
	assign fetchGnt = fetchPort.req && !hostPort.req && !dataPort.req;

	assign hostPort.grant = hostGnt;
	assign dataPort.grant = dataGnt;
	assign fetchPort.grant = fetchGnt;

	assign memReq = hostGnt || dataGnt || fetchGnt;

	always_comb begin
		memWe = 1'b0;
		memAddr = '0;
		memWdata = '0;
		if (hostGnt) begin
			memWe = hostPort.we;
			memAddr = hostPort.addr;
			memWdata = hostPort.wdata;
		end else if (dataGnt) begin
			memWe = dataPort.we;
			memAddr = dataPort.addr;
			memWdata = dataPort.wdata;
		end else if (fetchGnt) begin
			memAddr = fetchPort.addr;
		end
	end

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			hostRd <= 1'b0;
			dataRd <= 1'b0;
			fetchRd <= 1'b0;
		end else begin
			hostRd <= hostGnt && !hostPort.we;
			dataRd <= dataGnt && !dataPort.we;
			fetchRd <= fetchGnt;
		end
	end

	// read data steered to its owner only
	assign hostPort.rdata = hostRd ? memRdata : '0;
	assign dataPort.rdata = dataRd ? memRdata : '0;
	assign fetchPort.rdata = fetchRd ? memRdata : '0;

endmodule

`default_nettype wire

// File: rtl/memPortIf.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// grant comes in the request cycle, rdata one cycle later
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

interface memPortIf;
	import wiscPkg::*;

	logic              req;
	logic              we;
	logic [ADDR_W-1:0] addr;
	logic [DATA_W-1:0] wdata;
	logic              grant;
	logic [DATA_W-1:0] rdata;

	modport requester (output req, we, addr, wdata, input grant, rdata);
	modport arbiter (input req, we, addr, wdata, output grant, rdata);

endinterface

`default_nettype wire

// File: rtl/wiscPkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// memory is word addressed with ADDR_W bits of address
// opcodes outside opcodeT are illegal and stop the core
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package wiscPkg;

	localparam int DATA_W = 16;
	localparam int ADDR_W = 8;
	localparam int MEM_DEPTH = 256;
	localparam int REG_CNT = 8;
	localparam int REG_W = $clog2(REG_CNT);

	// opcode lives in instr[15:11]
	typedef enum logic [4:0] {
		OP_HALT = 5'b00000,
		OP_ADDI = 5'b01000,
		OP_BEQZ = 5'b01100,
		OP_ST   = 5'b10000,
		OP_LD   = 5'b10001,
		OP_ADD  = 5'b11000,
		OP_SUB  = 5'b11001,
		OP_XOR  = 5'b11010,
		OP_AND  = 5'b11011
	} opcodeT;

	typedef enum logic [1:0] {
		IDLE,
		RUN,
		HALTED
	} procStateT;

	// instructions that write Rd
	function automatic logic writesRd(opcodeT op);
		return op inside {OP_ADD, OP_SUB, OP_AND, OP_XOR, OP_ADDI, OP_LD};
	endfunction

endpackage

`default_nettype wire
